// ==== verilog/memBridge_consts.svh ====
`ifndef MEMBRIDGE_CONSTS_SVH
`define MEMBRIDGE_CONSTS_SVH

// byte address width into the internal RAM
`define MB_ADDR_W 12

// RAM size in bytes, matches the address width
`define MB_RAM_DEPTH 4096

// queue entries per port
// also the credits each requester holds after reset
`define MB_REQ_DEPTH 2

// access length field, holds 1, 2 or 4
`define MB_LEN_W 3

`endif

// ==== verilog/memBridgePkg.sv ====
`include "memBridge_consts.svh"

package memBridgePkg;

    typedef logic [`MB_ADDR_W-1:0] addr_t;

    typedef logic [31:0] word_t;

    typedef logic [7:0] byte_t;

    // length in bytes
    typedef logic [`MB_LEN_W-1:0] len_t;

    // owner of a request, carried down to the assembler
    typedef enum logic {
        SRC_FETCH,
        SRC_DATA
    } reqSrc_e;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_BEAT
    } seqState_e;

endpackage

// ==== verilog/memReqArbiter.sv ====
`timescale 1ns/100ps
`include "memBridge_consts.svh"

module memReqArbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_fetchValid,
    input  memBridgePkg::addr_t     i_fetchAddr,
    input  logic                    i_dataValid,
    input  logic                    i_dataStore,
    input  memBridgePkg::len_t      i_dataLen,
    input  memBridgePkg::addr_t     i_dataAddr,
    input  memBridgePkg::word_t     i_dataWdata,
    input  logic                    i_reqTake,
    output logic                    o_reqValid,
    output memBridgePkg::reqSrc_e   o_reqSrc,
    output logic                    o_reqStore,
    output memBridgePkg::len_t      o_reqLen,
    output memBridgePkg::addr_t     o_reqAddr,
    output memBridgePkg::word_t     o_reqWdata,
    output logic                    o_fetchCredit,
    output logic                    o_dataCredit
);
    localparam int DEPTH = `MB_REQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    memBridgePkg::addr_t fetchAddrQ [DEPTH];
    logic [PTR_W-1:0]    fetchWrPtr;
    logic [PTR_W-1:0]    fetchRdPtr;
    logic [CNT_W-1:0]    fetchCnt;

    logic                dataStoreQ [DEPTH];
    memBridgePkg::len_t  dataLenQ [DEPTH];
    memBridgePkg::addr_t dataAddrQ [DEPTH];
    memBridgePkg::word_t dataWdataQ [DEPTH];
    logic [PTR_W-1:0]    dataWrPtr;
    logic [PTR_W-1:0]    dataRdPtr;
    logic [CNT_W-1:0]    dataCnt;

    logic fetchAvail;
    logic dataAvail;
    logic popFetch;
    logic popData;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // credits bound arrivals, so a push never meets a full queue
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchWrPtr <= '0;
            fetchRdPtr <= '0;
            fetchCnt   <= '0;
            dataWrPtr  <= '0;
            dataRdPtr  <= '0;
            dataCnt    <= '0;
        end else begin
            if (i_fetchValid) fetchWrPtr <= nextPtr(fetchWrPtr);
            if (popFetch) fetchRdPtr <= nextPtr(fetchRdPtr);
            fetchCnt <= fetchCnt + CNT_W'(i_fetchValid) - CNT_W'(popFetch);
            if (i_dataValid) dataWrPtr <= nextPtr(dataWrPtr);
            if (popData) dataRdPtr <= nextPtr(dataRdPtr);
            dataCnt <= dataCnt + CNT_W'(i_dataValid) - CNT_W'(popData);
        end
    end

    always_ff @(posedge clk) begin
        if (i_fetchValid) begin
            fetchAddrQ[fetchWrPtr] <= i_fetchAddr;
        end
        if (i_dataValid) begin
            dataStoreQ[dataWrPtr] <= i_dataStore;
            dataLenQ[dataWrPtr]   <= i_dataLen;
            dataAddrQ[dataWrPtr]  <= i_dataAddr;
            dataWdataQ[dataWrPtr] <= i_dataWdata;
        end
    end

    assign fetchAvail = (fetchCnt != '0);
    assign dataAvail  = (dataCnt != '0);

    // data port wins whenever it has something queued
    assign o_reqValid = dataAvail || fetchAvail;
    assign popData    = i_reqTake && dataAvail;
    assign popFetch   = i_reqTake && !dataAvail && fetchAvail;

    always_comb begin
        if (dataAvail) begin
            o_reqSrc   = memBridgePkg::SRC_DATA;
            o_reqStore = dataStoreQ[dataRdPtr];
            o_reqLen   = dataLenQ[dataRdPtr];
            o_reqAddr  = dataAddrQ[dataRdPtr];
            o_reqWdata = dataWdataQ[dataRdPtr];
        end else begin
            o_reqSrc   = memBridgePkg::SRC_FETCH;
            o_reqStore = 1'b0;
            o_reqLen   = memBridgePkg::len_t'(4);
            o_reqAddr  = fetchAddrQ[fetchRdPtr];
            o_reqWdata = '0;
        end
    end

    assign o_fetchCredit = popFetch;
    assign o_dataCredit  = popData;

endmodule

// ==== verilog/byteSequencer.sv ====
`timescale 1ns/100ps

module byteSequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_ioFull,
    input  logic                    i_reqValid,
    input  memBridgePkg::reqSrc_e   i_reqSrc,
    input  logic                    i_reqStore,
    input  memBridgePkg::len_t      i_reqLen,
    input  memBridgePkg::addr_t     i_reqAddr,
    input  memBridgePkg::word_t     i_reqWdata,
    output logic                    o_reqTake,
    output logic                    o_beatValid,
    output logic                    o_beatWrite,
    output memBridgePkg::addr_t     o_beatAddr,
    output memBridgePkg::byte_t     o_beatWbyte,
    output memBridgePkg::reqSrc_e   o_beatSrc,
    output logic [1:0]              o_beatIdx,
    output logic                    o_beatLast,
    output logic                    o_storeDone
);
    memBridgePkg::seqState_e state;
    logic [1:0]              byteCnt;

    // request being split
    memBridgePkg::reqSrc_e   curSrc;
    logic                    curStore;
    memBridgePkg::len_t      curLen;
    memBridgePkg::addr_t     curAddr;
    memBridgePkg::word_t     curWdata;

    memBridgePkg::len_t      lastIdx;
    logic                    isLast;
    logic                    issue;
    logic                    take;

    assign lastIdx = curLen - memBridgePkg::len_t'(1);
    assign isLast  = (state == memBridgePkg::SEQ_BEAT) &&
                     (memBridgePkg::len_t'(byteCnt) == lastIdx);
    assign issue   = (state == memBridgePkg::SEQ_BEAT) && !i_ioFull;

    // next request is taken while the last beat goes out, no bubble
    assign take = !i_ioFull && ((state == memBridgePkg::SEQ_IDLE) || isLast);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= memBridgePkg::SEQ_IDLE;
            byteCnt <= '0;
        end else if (!i_ioFull) begin
            if (take) begin
                byteCnt <= '0;
                if (i_reqValid) begin
                    state <= memBridgePkg::SEQ_BEAT;
                end else begin
                    state <= memBridgePkg::SEQ_IDLE;
                end
            end else begin
                byteCnt <= byteCnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && i_reqValid) begin
            curSrc   <= i_reqSrc;
            curStore <= i_reqStore;
            curLen   <= i_reqLen;
            curAddr  <= i_reqAddr;
            curWdata <= i_reqWdata;
        end
    end

    assign o_reqTake   = take;
    assign o_beatValid = issue;
    assign o_beatWrite = curStore;
    assign o_beatAddr  = curAddr + memBridgePkg::addr_t'(byteCnt);
    assign o_beatWbyte = curWdata[8*byteCnt +: 8];
    assign o_beatSrc   = curSrc;
    assign o_beatIdx   = byteCnt;
    assign o_beatLast  = isLast;

    // store completes at issue of its last write
    assign o_storeDone = issue && curStore && isLast;

endmodule

// ==== verilog/byteRam.sv ====
`timescale 1ns/100ps
`include "memBridge_consts.svh"

module byteRam (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_ioFull,
    input  logic                    i_beatValid,
    input  logic                    i_beatWrite,
    input  memBridgePkg::addr_t     i_beatAddr,
    input  memBridgePkg::byte_t     i_beatWbyte,
    input  memBridgePkg::reqSrc_e   i_beatSrc,
    input  logic [1:0]              i_beatIdx,
    input  logic                    i_beatLast,
    output logic                    o_rdValid,
    output memBridgePkg::byte_t     o_rdByte,
    output memBridgePkg::reqSrc_e   o_rdSrc,
    output logic [1:0]              o_rdIdx,
    output logic                    o_rdLast
);
    memBridgePkg::byte_t mem [`MB_RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (!i_ioFull && i_beatValid && i_beatWrite) begin
            mem[i_beatAddr] <= i_beatWbyte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_rdValid <= 1'b0;
        end else if (!i_ioFull) begin
            o_rdValid <= i_beatValid && !i_beatWrite;
        end
    end

    // read byte and its tag move together, one cycle late
    always_ff @(posedge clk) begin
        if (!i_ioFull && i_beatValid && !i_beatWrite) begin
            o_rdByte <= mem[i_beatAddr];
            o_rdSrc  <= i_beatSrc;
            o_rdIdx  <= i_beatIdx;
            o_rdLast <= i_beatLast;
        end
    end

endmodule

// ==== verilog/wordAssembler.sv ====
`timescale 1ns/100ps

module wordAssembler (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_ioFull,
    input  logic                    i_rdValid,
    input  memBridgePkg::byte_t     i_rdByte,
    input  memBridgePkg::reqSrc_e   i_rdSrc,
    input  logic [1:0]              i_rdIdx,
    input  logic                    i_rdLast,
    input  logic                    i_storeDone,
    output logic                    o_fetchDone,
    output memBridgePkg::word_t     o_fetchInst,
    output logic                    o_dataDone,
    output memBridgePkg::word_t     o_dataRdata
);
    memBridgePkg::word_t holdWord;
    memBridgePkg::word_t lastWord;
    logic                fetchDoneR;
    logic                dataDoneR;
    logic [1:0]          pendStore;
    logic [1:0]          pendNext;
    logic                wordDone;
    logic                dataLoadDone;

    assign wordDone     = i_rdValid && i_rdLast;
    assign dataLoadDone = wordDone && (i_rdSrc == memBridgePkg::SRC_DATA);
    assign pendNext     = pendStore + {1'b0, i_storeDone};

    // merge the final byte and zero the bytes above it
    always_comb begin
        lastWord = holdWord;
        lastWord[8*i_rdIdx +: 8] = i_rdByte;
        for (int b = 0; b < 4; b++) begin
            if (b > i_rdIdx) lastWord[8*b +: 8] = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_ioFull && i_rdValid && !i_rdLast) begin
            holdWord[8*i_rdIdx +: 8] <= i_rdByte;
        end
    end

    // a store finishing next to a data load waits one cycle behind it
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDoneR <= 1'b0;
            dataDoneR  <= 1'b0;
            pendStore  <= '0;
        end else if (!i_ioFull) begin
            fetchDoneR <= wordDone && (i_rdSrc == memBridgePkg::SRC_FETCH);
            if (dataLoadDone) begin
                dataDoneR <= 1'b1;
                pendStore <= pendNext;
            end else if (pendNext != '0) begin
                dataDoneR <= 1'b1;
                pendStore <= pendNext - 2'd1;
            end else begin
                dataDoneR <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_ioFull) begin
            if (wordDone && (i_rdSrc == memBridgePkg::SRC_FETCH)) begin
                o_fetchInst <= lastWord;
            end
            if (dataLoadDone) begin
                o_dataRdata <= lastWord;
            end else if (pendNext != '0) begin
                o_dataRdata <= '0;
            end
        end
    end

    // pulses wait out a stall
    assign o_fetchDone = fetchDoneR && !i_ioFull;
    assign o_dataDone  = dataDoneR && !i_ioFull;

endmodule

// ==== verilog/memBridgeTop.sv ====
`timescale 1ns/100ps

module memBridgeTop (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_ioFull,
    input  logic                    i_fetchValid,
    input  memBridgePkg::addr_t     i_fetchAddr,
    output logic                    o_fetchCredit,
    output logic                    o_fetchDone,
    output memBridgePkg::word_t     o_fetchInst,
    input  logic                    i_dataValid,
    input  logic                    i_dataStore,
    input  memBridgePkg::len_t      i_dataLen,
    input  memBridgePkg::addr_t     i_dataAddr,
    input  memBridgePkg::word_t     i_dataWdata,
    output logic                    o_dataCredit,
    output logic                    o_dataDone,
    output memBridgePkg::word_t     o_dataRdata
);
    // arbiter to sequencer
    logic                  reqValid;
    logic                  reqTake;
    memBridgePkg::reqSrc_e reqSrc;
    logic                  reqStore;
    memBridgePkg::len_t    reqLen;
    memBridgePkg::addr_t   reqAddr;
    memBridgePkg::word_t   reqWdata;

    // sequencer to RAM
    logic                  beatValid;
    logic                  beatWrite;
    memBridgePkg::addr_t   beatAddr;
    memBridgePkg::byte_t   beatWbyte;
    memBridgePkg::reqSrc_e beatSrc;
    logic [1:0]            beatIdx;
    logic                  beatLast;
    logic                  storeDone;

    // RAM to assembler
    logic                  rdValid;
    memBridgePkg::byte_t   rdByte;
    memBridgePkg::reqSrc_e rdSrc;
    logic [1:0]            rdIdx;
    logic                  rdLast;

    memReqArbiter u_arbiter (
        .clk(clk), .rst(rst),
        .i_fetchValid(i_fetchValid), .i_fetchAddr(i_fetchAddr),
        .i_dataValid(i_dataValid), .i_dataStore(i_dataStore), .i_dataLen(i_dataLen),
        .i_dataAddr(i_dataAddr), .i_dataWdata(i_dataWdata),
        .i_reqTake(reqTake), .o_reqValid(reqValid), .o_reqSrc(reqSrc),
        .o_reqStore(reqStore), .o_reqLen(reqLen), .o_reqAddr(reqAddr),
        .o_reqWdata(reqWdata),
        .o_fetchCredit(o_fetchCredit), .o_dataCredit(o_dataCredit)
    );

    byteSequencer u_sequencer (
        .clk(clk), .rst(rst), .i_ioFull(i_ioFull),
        .i_reqValid(reqValid), .i_reqSrc(reqSrc), .i_reqStore(reqStore),
        .i_reqLen(reqLen), .i_reqAddr(reqAddr), .i_reqWdata(reqWdata),
        .o_reqTake(reqTake), .o_beatValid(beatValid), .o_beatWrite(beatWrite),
        .o_beatAddr(beatAddr), .o_beatWbyte(beatWbyte), .o_beatSrc(beatSrc),
        .o_beatIdx(beatIdx), .o_beatLast(beatLast), .o_storeDone(storeDone)
    );

    byteRam u_ram (
        .clk(clk), .rst(rst), .i_ioFull(i_ioFull),
        .i_beatValid(beatValid), .i_beatWrite(beatWrite), .i_beatAddr(beatAddr),
        .i_beatWbyte(beatWbyte), .i_beatSrc(beatSrc), .i_beatIdx(beatIdx),
        .i_beatLast(beatLast),
        .o_rdValid(rdValid), .o_rdByte(rdByte), .o_rdSrc(rdSrc),
        .o_rdIdx(rdIdx), .o_rdLast(rdLast)
    );

    wordAssembler u_assembler (
        .clk(clk), .rst(rst), .i_ioFull(i_ioFull),
        .i_rdValid(rdValid), .i_rdByte(rdByte), .i_rdSrc(rdSrc),
        .i_rdIdx(rdIdx), .i_rdLast(rdLast), .i_storeDone(storeDone),
        .o_fetchDone(o_fetchDone), .o_fetchInst(o_fetchInst),
        .o_dataDone(o_dataDone), .o_dataRdata(o_dataRdata)
    );

endmodule

// ==== tb/memBridgeTb.sv ====
`timescale 1ns/100ps
`include "memBridge_consts.svh"

module memBridgeTb;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  ioFull;
    logic                  fetchValid;
    memBridgePkg::addr_t   fetchAddr;
    logic                  fetchCredit;
    logic                  fetchDone;
    memBridgePkg::word_t   fetchInst;
    logic                  dataValid;
    logic                  dataStore;
    memBridgePkg::len_t    dataLen;
    memBridgePkg::addr_t   dataAddr;
    memBridgePkg::word_t   dataWdata;
    logic                  dataCredit;
    logic                  dataDone;
    memBridgePkg::word_t   dataRdata;

    // stimulus lines, one entry each
    logic [7:0]            opQ [$];
    logic [31:0]           addrQ [$];
    int                    lenQ [$];
    logic [31:0]           wdataQ [$];
    logic [31:0]           expQ [$];
    int                    stallQ [$];

    // expected results per port, in request order
    memBridgePkg::word_t   expFetchQ [$];
    memBridgePkg::word_t   expDataQ [$];
    memBridgePkg::word_t   expWord;

    int seed = 72;
    int fetchCredits = `MB_REQ_DEPTH;
    int dataCredits = `MB_REQ_DEPTH;
    int cycleCnt = 0;
    int cycleLimit = 100000;

    always #5 clk = ~clk;

    memBridgeTop u_dut (
        .clk(clk), .rst(rst), .i_ioFull(ioFull),
        .i_fetchValid(fetchValid), .i_fetchAddr(fetchAddr),
        .o_fetchCredit(fetchCredit), .o_fetchDone(fetchDone), .o_fetchInst(fetchInst),
        .i_dataValid(dataValid), .i_dataStore(dataStore), .i_dataLen(dataLen),
        .i_dataAddr(dataAddr), .i_dataWdata(dataWdata),
        .o_dataCredit(dataCredit), .o_dataDone(dataDone), .o_dataRdata(dataRdata)
    );

    task automatic stopWithFail(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp) begin
            stopWithFail($sformatf("[ERROR] %0d ns: %s expected %h, got %h",
                                   $time, what, exp, got));
        end
    endtask

    task automatic readStimulus();
        int          fd;
        int          n;
        int          len;
        int          stall;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expv;
        fd = $fopen("tb/memBridge_stimulus.txt", "r");
        if (fd == 0) begin
            stopWithFail("could not open the stimulus file tb/memBridge_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // skip comments and blank lines
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %d %h %h %d", op, addr, len, wdata, expv, stall);
                    if (n == 6) begin
                        opQ.push_back(op);
                        addrQ.push_back(addr);
                        lenQ.push_back(len);
                        wdataQ.push_back(wdata);
                        expQ.push_back(expv);
                        stallQ.push_back(stall);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // one request per cycle in file order, only while a credit is held
    task automatic driveRequests();
        int idx;
        logic isFetch;
        idx = 0;
        while (idx < opQ.size()) begin
            @(posedge clk);
            #1;
            fetchValid = 1'b0;
            dataValid  = 1'b0;
            ioFull     = (stallQ[idx] != 0) && (($random(seed) & 3) == 0);
            isFetch    = (opQ[idx] == "F");
            if (isFetch && fetchCredits > 0) begin
                fetchValid = 1'b1;
                fetchAddr  = memBridgePkg::addr_t'(addrQ[idx]);
                fetchCredits--;
                expFetchQ.push_back(expQ[idx]);
                idx++;
            end else if (!isFetch && dataCredits > 0) begin
                dataValid = 1'b1;
                dataStore = (opQ[idx] == "S");
                dataLen   = memBridgePkg::len_t'(lenQ[idx]);
                dataAddr  = memBridgePkg::addr_t'(addrQ[idx]);
                dataWdata = wdataQ[idx];
                dataCredits--;
                expDataQ.push_back(expQ[idx]);
                idx++;
            end
        end
        @(posedge clk);
        #1;
        fetchValid = 1'b0;
        dataValid  = 1'b0;
        ioFull     = 1'b0;
    endtask

    // outputs settle by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (fetchCredit) fetchCredits++;
            if (dataCredit) dataCredits++;
            checkValue(32'(fetchCredits >= 0 && fetchCredits <= `MB_REQ_DEPTH), 32'd1,
                       "fetch credit count in range");
            checkValue(32'(dataCredits >= 0 && dataCredits <= `MB_REQ_DEPTH), 32'd1,
                       "data credit count in range");
            if (fetchDone) begin
                if (expFetchQ.size() == 0) begin
                    stopWithFail("a fetch done pulse came with no fetch outstanding");
                end else begin
                    expWord = expFetchQ.pop_front();
                    checkValue(fetchInst, expWord, "fetch word");
                end
            end
            if (dataDone) begin
                if (expDataQ.size() == 0) begin
                    stopWithFail("a data done pulse came with no data request outstanding");
                end else begin
                    expWord = expDataQ.pop_front();
                    checkValue(dataRdata, expWord, "data result");
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCnt++;
        if (cycleCnt >= cycleLimit) begin
            stopWithFail($sformatf("timeout after %0d cycles with %0d fetch and %0d data %s",
                                   cycleCnt, expFetchQ.size(), expDataQ.size(),
                                   "results still outstanding"));
        end
    end

    initial begin
        rst        = 1'b1;
        ioFull     = 1'b0;
        fetchValid = 1'b0;
        fetchAddr  = '0;
        dataValid  = 1'b0;
        dataStore  = 1'b0;
        dataLen    = '0;
        dataAddr   = '0;
        dataWdata  = '0;
        readStimulus();
        cycleLimit = 40 * opQ.size() + 200;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        driveRequests();
        while (expFetchQ.size() != 0 || expDataQ.size() != 0) begin
            @(negedge clk);
        end
        // idle window to catch stray done pulses
        repeat (8) @(negedge clk);
        checkValue(fetchCredits, `MB_REQ_DEPTH, "fetch credits at end");
        checkValue(dataCredits, `MB_REQ_DEPTH, "data credits at end");
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== memBridge.f ====
+incdir+verilog
verilog/memBridgePkg.sv
verilog/memReqArbiter.sv
verilog/byteSequencer.sv
verilog/byteRam.sv
verilog/wordAssembler.sv
verilog/memBridgeTop.sv
tb/memBridgeTb.sv

// ==== tb/memBridge_stimulus.txt ====
# op addr(hex) len wdata(hex) expected(hex) stall
# op is F fetch, L load, S store; stall 1 lets random i_ioFull run on that line
S 100 4 11223344 00000000 0
S 104 2 0000beef 00000000 0
S 106 1 000000a5 00000000 0
S 107 1 0000005a 00000000 0
S 108 4 deadc0de 00000000 0
S 10c 2 00007788 00000000 0
S 10e 2 00009966 00000000 0
F 100 4 00000000 11223344 0
F 104 4 00000000 5aa5beef 0
F 108 4 00000000 deadc0de 0
F 10c 4 00000000 99667788 0
L 100 4 00000000 11223344 0
L 104 4 00000000 5aa5beef 0
L 108 4 00000000 deadc0de 0
L 10c 4 00000000 99667788 0
L 101 1 00000000 00000033 0
L 102 2 00000000 00001122 0
L 105 1 00000000 000000be 0
L 109 2 00000000 0000adc0 0
L 10b 1 00000000 000000de 0
L 10d 2 00000000 00006677 0
L 107 1 00000000 0000005a 0
S 200 4 cafef00d 00000000 1
F 100 4 00000000 11223344 1
S 204 2 00001357 00000000 1
F 104 4 00000000 5aa5beef 1
L 200 4 00000000 cafef00d 1
F 108 4 00000000 deadc0de 1
L 202 2 00000000 0000cafe 1
S 206 1 0000002a 00000000 1
F 10c 4 00000000 99667788 1
S 207 1 0000007e 00000000 1
L 204 4 00000000 7e2a1357 1
F 100 4 00000000 11223344 1
L 201 1 00000000 000000f0 1
S 208 4 01234567 00000000 1
F 104 4 00000000 5aa5beef 1
L 209 2 00000000 00002345 1
L 208 4 00000000 01234567 1
